/* files.f */
src/imager_pkg.sv
src/raster_if.sv
src/imager_regs.sv
src/frame_timing.sv
src/pattern_gen.sv
src/imager_top.sv
sim/imager_tb.sv

/* Makefile */
TOP = imager_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o sim_bin

run: build
	./obj_dir/sim_bin | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f
	verilator --lint-only --top-module imager_top src/imager_pkg.sv src/raster_if.sv \
		src/imager_regs.sv src/frame_timing.sv src/pattern_gen.sv src/imager_top.sv

clean:
	rm -rf obj_dir sim.log

/* sim/imager_tb.sv */
`timescale 1ns/1ps

module imager_tb import imager_pkg::*; ();

   // stream geometry used by the tests
   localparam int act_cols   = 16;
   localparam int virt_cols  = 8;
   localparam int act_rows   = 8;
   localparam int virt_rows  = 6;
   localparam int porch      = virt_cols / 2;
   localparam int tot_cols   = act_cols + virt_cols;
   localparam int tot_rows   = act_rows + virt_rows;
   localparam int sync_start = 2;
   localparam int sync_len   = 3;
   localparam int num_frames = 40;
   localparam longint limit_ns = longint'(num_frames) * tot_cols * tot_rows * 20 * 2;

   logic        clk;
   logic        reset_n;
   logic [5:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [5:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic [9:0]  dat;
   logic        fv;
   logic        lv;
   logic        sync;

   integer      seed = 32'h2873_664c;
   int          errors = 0;

   // monitor state
   logic [3:0]  mode_sh = 4'd0;
   logic [31:0] seed_sh = '0;
   logic [31:0] ref_lfsr = 32'd1;
   logic [15:0] exp_frame = '0;
   logic        frame_open = 1'b0;
   logic        stopping = 1'b1;
   logic        running = 1'b0;
   logic        prev_fv = 1'b0;
   logic        prev_lv = 1'b0;
   int          line_idx = 0;
   int          col_idx = 0;
   int          pix_cnt = 0;
   int          frames_done = 0;
   int          frames_in_mode = 0;
   logic [9:0]  noise_buf [0:4095];
   logic [9:0]  exp_dat;

   imager_top uut (
      .clk, .reset_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .dat, .fv, .lv, .sync
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   function automatic logic [9:0] expected_pixel(input logic [3:0] m, input int row,
                                                 input int col, input logic [15:0] frame,
                                                 input int count, input logic [31:0] lfsr);
      int val;
      case (m)
         4'd0:    val = int'(lfsr[9:0]);
         4'd1:    val = row;
         4'd2:    val = col;
         4'd3:    val = row + col;
         4'd4:    val = int'(frame);
         4'd5:    val = int'(frame) + col + row;
         4'd7:    val = count;
         default: val = ((row % 2) == 1 && (col % 2) == 1) ? 32'h3FF : 0;
      endcase
      return val[9:0];
   endfunction

   // xnor feedback from bits 31, 21, 1 and 0
   function automatic logic [31:0] lfsr_step(input logic [31:0] r);
      return {r[30:0], ~(r[31] ^ r[21] ^ r[1] ^ r[0])};
   endfunction

   // raster monitor, samples the outputs at the rising edge
   always @(posedge clk) begin
      if (reset_n) begin
         if (lv && !fv) begin
            $display("[ERROR] lv high while fv low at %0t", $time);
            errors++;
         end
         if (fv && !prev_fv) begin
            if (frame_open) exp_frame = exp_frame + 16'd1;
            frame_open = 1'b1;
            line_idx = 0;
            pix_cnt = 0;
            frames_in_mode++;
            if (seed_sh != 0) ref_lfsr = seed_sh;
         end
         if (lv) begin
            exp_dat = expected_pixel(mode_sh, line_idx, porch + col_idx, exp_frame,
                                     pix_cnt, ref_lfsr);
            if (dat !== exp_dat) begin
               $display("[ERROR] dat: got 0x%03h expected 0x%03h (mode %0d row %0d col %0d)",
                        dat, exp_dat, mode_sh, line_idx, porch + col_idx);
               errors++;
            end
            if (mode_sh == 4'd0 && pix_cnt < 4096) begin
               if (frames_in_mode == 1) begin
                  noise_buf[pix_cnt] = dat;
               end else if (frames_in_mode == 2 && seed_sh != 0 && dat !== noise_buf[pix_cnt]) begin
                  $display("[ERROR] dat: got 0x%03h expected 0x%03h (noise frame repeat)",
                           dat, noise_buf[pix_cnt]);
                  errors++;
               end
            end
            ref_lfsr = lfsr_step(ref_lfsr);
            pix_cnt++;
            col_idx++;
         end else if (dat !== 10'd0) begin
            $display("[ERROR] dat: got 0x%03h expected 0x000 (lv low)", dat);
            errors++;
         end
         if (!lv && prev_lv) begin
            if (!stopping && col_idx != act_cols) begin
               $display("[ERROR] lv: line length 0x%0h expected 0x%0h", col_idx, act_cols);
               errors++;
            end
            line_idx++;
            col_idx = 0;
         end
         if (!fv && prev_fv && !stopping) begin
            if (line_idx != act_rows) begin
               $display("[ERROR] fv: line count 0x%0h expected 0x%0h", line_idx, act_rows);
               errors++;
            end
            frames_done++;
         end
         prev_fv = fv;
         prev_lv = lv;
      end
   end

   task automatic axi_write(input logic [5:0] addr, input logic [31:0] data);
      #1;
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wstrb   = 4'hF;
      wvalid  = 1'b1;
      do @(posedge clk); while (!(awready && wready));
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      do @(posedge clk); while (!bvalid);
      if (bresp !== 2'b00) begin
         $display("[ERROR] bresp: got 0x%0h expected 0x0", bresp);
         errors++;
      end
      #1;
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [5:0] addr, output logic [31:0] data);
      #1;
      araddr  = addr;
      arvalid = 1'b1;
      do @(posedge clk); while (!arready);
      #1;
      arvalid = 1'b0;
      rready  = 1'b1;
      do @(posedge clk); while (!rvalid);
      data = rdata;
      if (rresp !== 2'b00) begin
         $display("[ERROR] rresp: got 0x%0h expected 0x0", rresp);
         errors++;
      end
      #1;
      rready = 1'b0;
   endtask

   task automatic check_reg(input logic [5:0] addr, input logic [31:0] mask);
      logic [31:0] val;
      logic [31:0] got;
      val = $random(seed);
      if (addr == reg_ctrl) val[0] = 1'b0;
      if (addr == reg_seed) seed_sh = val;
      axi_write(addr, val);
      axi_read(addr, got);
      if (got !== (val & mask)) begin
         $display("[ERROR] rdata at 0x%02h: got 0x%08h expected 0x%08h", addr, got, val & mask);
         errors++;
      end
   endtask

   task automatic wait_frame_start();
      logic p;
      do begin
         p = fv;
         @(posedge clk);
      end while (!(fv && !p));
   endtask

   task automatic run_frames(input int n);
      int target;
      target = frames_done + n;
      while (frames_done < target) @(posedge clk);
   endtask

   // stop inside the active rows so that no frame boundary is cut
   task automatic stop_stream();
      if (running) begin
         wait_frame_start();
         // the monitor takes this frame start before the stream is cut
         #1;
      end
      stopping   = 1'b1;
      frame_open = 1'b0;
      axi_write(reg_ctrl, {24'h0, mode_sh, 4'h0});
      running = 1'b0;
      repeat (4) @(posedge clk);
   endtask

   task automatic start_mode(input logic [3:0] m);
      stop_stream();
      mode_sh        = m;
      frames_in_mode = 0;
      stopping       = 1'b0;
      axi_write(reg_ctrl, {24'h0, m, 4'h1});
      running = 1'b1;
   endtask

   task automatic write_geometry();
      axi_write(reg_active, {4'h0, 12'(act_rows), 4'h0, 12'(act_cols)});
      axi_write(reg_virtual, {4'h0, 12'(virt_rows), 4'h0, 12'(virt_cols)});
      axi_write(reg_sync, {3'h0, 13'(sync_start), 4'h0, 12'(sync_len)});
   endtask

   task automatic check_sync();
      int n;
      int fall_at;
      int low_cycles;
      logic p;
      wait_frame_start();
      n = 0;
      fall_at = -1;
      low_cycles = 0;
      p = sync;
      while (n < tot_rows * tot_cols) begin
         @(posedge clk);
         n++;
         if (!sync) low_cycles++;
         if (!sync && p && fall_at < 0) fall_at = n;
         p = sync;
      end
      if (fall_at != sync_start * tot_cols - 1) begin
         $display("[ERROR] sync: fall at cycle 0x%0h expected 0x%0h", fall_at,
                  sync_start * tot_cols - 1);
         errors++;
      end
      if (low_cycles != sync_len * tot_cols) begin
         $display("[ERROR] sync: low for 0x%0h cycles expected 0x%0h", low_cycles,
                  sync_len * tot_cols);
         errors++;
      end
   endtask

   initial begin
      #(limit_ns);
      $display("timeout: the stream did not deliver the expected frames in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      logic [31:0] status;
      logic [3:0]  modes [8];
      modes = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd7, 4'd8, 4'd6};
      reset_n = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (10) @(posedge clk);
      #1 reset_n = 1'b1;
      if (dat !== 10'd0 || fv !== 1'b0 || lv !== 1'b0 || sync !== 1'b1 ||
          bvalid !== 1'b0 || rvalid !== 1'b0) begin
         $display("outputs are not at their reset values after reset");
         errors++;
      end

      // seed 0, the LFSR runs on from its reset value across frames
      write_geometry();
      start_mode(4'd0);
      run_frames(2);

      stop_stream();
      check_reg(reg_ctrl, 32'h0000_00F1);
      check_reg(reg_active, 32'h0FFF_0FFF);
      check_reg(reg_virtual, 32'h0FFF_0FFF);
      check_reg(reg_sync, 32'h1FFF_0FFF);
      check_reg(reg_seed, 32'hFFFF_FFFF);
      write_geometry();
      seed_sh = 32'hACE1_0001;
      axi_write(reg_seed, seed_sh);

      // nonzero seed restarts the sequence each frame
      start_mode(4'd0);
      run_frames(2);

      wait_frame_start();
      axi_read(reg_status, status);
      if (status !== {16'h0, exp_frame}) begin
         $display("[ERROR] reg_status: got 0x%08h expected 0x%08h", status, {16'h0, exp_frame});
         errors++;
      end

      foreach (modes[i]) begin
         start_mode(modes[i]);
         run_frames(1);
      end

      check_sync();

      // disable mid frame, then restart at row 0
      start_mode(4'd1);
      wait_frame_start();
      repeat (30) @(posedge clk);
      #1;
      stopping   = 1'b1;
      frame_open = 1'b0;
      axi_write(reg_ctrl, 32'h0000_0010);
      running = 1'b0;
      if (dat !== 10'd0 || fv !== 1'b0 || lv !== 1'b0) begin
         $display("[ERROR] outputs after disable: dat 0x%03h fv 0x%0h lv 0x%0h", dat, fv, lv);
         errors++;
      end
      repeat (4) @(posedge clk);
      stopping = 1'b0;
      axi_write(reg_ctrl, 32'h0000_0011);
      running = 1'b1;
      run_frames(1);

      $display("checks done, %0d errors, %0d frames", errors, frames_done);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* src/imager_top.sv */
`timescale 1ns/1ps

module imager_top import imager_pkg::*; #(
   parameter int DATA_WIDTH = $bits(pixel_t),
   parameter int ROW_WIDTH  = $bits(row_t),
   parameter int COL_WIDTH  = $bits(col_t)
) (
   input  logic                  clk,
   input  logic                  reset_n,
   input  reg_addr_t             awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  reg_data_t             wdata,
   input  logic [3:0]            wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   output logic [1:0]            bresp,
   output logic                  bvalid,
   input  logic                  bready,
   input  reg_addr_t             araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output reg_data_t             rdata,
   output logic [1:0]            rresp,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [DATA_WIDTH-1:0] dat,
   output logic                  fv,
   output logic                  lv,
   output logic                  sync
);

   logic               enable;
   pattern_mode_t      mode;
   row_t               num_active_rows;
   row_t               num_virtual_rows;
   col_t               num_active_cols;
   col_t               num_virtual_cols;
   logic [ROW_WIDTH:0] sync_row_start;
   row_t               sync_rows;
   seed_t              noise_seed;

   raster_if #(.ROW_WIDTH(ROW_WIDTH), .COL_WIDTH(COL_WIDTH)) raster ();

   imager_regs u_regs (
      .clk, .reset_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .frame_count (raster.frame_count),
      .enable, .mode,
      .num_active_rows, .num_virtual_rows, .num_active_cols, .num_virtual_cols,
      .sync_row_start, .sync_rows, .noise_seed
   );

   frame_timing #(.ROW_WIDTH(ROW_WIDTH), .COL_WIDTH(COL_WIDTH)) u_timing (
      .clk, .reset_n, .enable,
      .num_active_rows, .num_virtual_rows, .num_active_cols, .num_virtual_cols,
      .sync_row_start, .sync_rows,
      .raster (raster.timing),
      .sync
   );

   pattern_gen #(.DATA_WIDTH(DATA_WIDTH)) u_pattern (
      .clk, .reset_n,
      .raster (raster.pattern),
      .mode, .noise_seed,
      .dat, .fv, .lv
   );

endmodule

/* src/pattern_gen.sv */
`timescale 1ns/1ps

module pattern_gen import imager_pkg::*; #(
   parameter int DATA_WIDTH = 10
) (
   input  logic                  clk,
   input  logic                  reset_n,
   raster_if.pattern             raster,
   input  pattern_mode_t         mode,
   input  seed_t                 noise_seed,
   output logic [DATA_WIDTH-1:0] dat,
   output logic                  fv,
   output logic                  lv
);

   seed_t                 lfsr;
   logic [DATA_WIDTH-1:0] pix_count;
   logic [DATA_WIDTH-1:0] bayer;
   logic [DATA_WIDTH-1:0] dat_sel;
   logic                  lfsr_fb;
   logic                  in_frame;

   // XNOR feedback, taps 31 21 1 0
   assign lfsr_fb  = ~(lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]);
   assign in_frame = raster.run && raster.frame_active;

   // red sits on odd rows and odd columns
   assign bayer = (raster.row[0] && raster.col[0]) ? '1 : '0;

   always_comb begin
      case (mode)
         mode_noise:      dat_sel = lfsr[DATA_WIDTH-1:0];
         mode_hgrad:      dat_sel = DATA_WIDTH'(raster.row);
         mode_vgrad:      dat_sel = DATA_WIDTH'(raster.col);
         mode_diag:       dat_sel = DATA_WIDTH'(raster.row + raster.col);
         mode_frame:      dat_sel = DATA_WIDTH'(raster.frame_count);
         mode_frame_diag: dat_sel = DATA_WIDTH'(raster.frame_count + raster.col + raster.row);
         mode_counter:    dat_sel = pix_count;
         default:         dat_sel = bayer;
      endcase
   end

   // noise source
   // a nonzero seed restarts the sequence every frame,
   // seed 0 lets it run on from the previous frame
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         lfsr <= 32'd1;
      end else if (!in_frame) begin
         if (|noise_seed) lfsr <= noise_seed;
      end else if (raster.pix_valid) begin
         lfsr <= {lfsr[30:0], lfsr_fb};
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pix_count <= '0;
      end else if (!raster.run) begin
         pix_count <= '0;
      end else if (raster.line_end_of_frame) begin
         pix_count <= '0;
      end else if (raster.pix_valid) begin
         pix_count <= pix_count + 1'b1;
      end
   end

   // output stage, one clock behind the raster position
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         dat <= '0;
         fv  <= 1'b0;
         lv  <= 1'b0;
      end else if (!raster.run) begin
         dat <= '0;
         fv  <= 1'b0;
         lv  <= 1'b0;
      end else begin
         fv  <= raster.frame_active;
         lv  <= raster.pix_valid;
         dat <= raster.pix_valid ? dat_sel : '0;
      end
   end

endmodule

/* src/frame_timing.sv */
`timescale 1ns/1ps

module frame_timing import imager_pkg::*; #(
   parameter int ROW_WIDTH = 12,
   parameter int COL_WIDTH = 12
) (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 enable,
   input  logic [ROW_WIDTH-1:0] num_active_rows,
   input  logic [ROW_WIDTH-1:0] num_virtual_rows,
   input  logic [COL_WIDTH-1:0] num_active_cols,
   input  logic [COL_WIDTH-1:0] num_virtual_cols,
   input  logic [ROW_WIDTH:0]   sync_row_start,
   input  logic [ROW_WIDTH-1:0] sync_rows,
   raster_if.timing             raster,
   output logic                 sync
);

   timing_state_t        state;
   logic [ROW_WIDTH-1:0] row;
   logic [COL_WIDTH-1:0] col;
   frame_cnt_t           frame_count;

   // geometry held for the whole frame
   logic [ROW_WIDTH-1:0] active_rows_q;
   logic [ROW_WIDTH-1:0] virtual_rows_q;
   logic [COL_WIDTH-1:0] active_cols_q;
   logic [COL_WIDTH-1:0] virtual_cols_q;

   logic [ROW_WIDTH:0]   total_rows;
   logic [COL_WIDTH:0]   total_cols;
   logic [COL_WIDTH-1:0] front_porch;
   logic [COL_WIDTH:0]   line_stop;
   logic [ROW_WIDTH:0]   next_row;
   logic [COL_WIDTH:0]   next_col;
   logic [ROW_WIDTH:0]   row_taken;
   logic [ROW_WIDTH:0]   sync_row_end;
   logic                 line_last;
   logic                 frame_last;
   logic                 row_step;
   logic                 frame_active;
   logic                 pix_valid;

   assign total_rows   = {1'b0, active_rows_q} + {1'b0, virtual_rows_q};
   assign total_cols   = {1'b0, active_cols_q} + {1'b0, virtual_cols_q};
   assign front_porch  = virtual_cols_q >> 1;
   assign line_stop    = {1'b0, active_cols_q} + {1'b0, front_porch};
   assign next_col     = {1'b0, col} + 1'b1;
   assign next_row     = {1'b0, row} + 1'b1;
   assign line_last    = next_col >= total_cols;
   assign frame_last   = line_last && (next_row >= total_rows);

   // the row value the counter takes at this clock, idle counts as row 0
   assign row_step     = (state == st_idle) || line_last;
   assign row_taken    = (state == st_idle || frame_last) ? '0 : next_row;
   assign sync_row_end = sync_row_start + {1'b0, sync_rows};

   assign frame_active = row < active_rows_q;
   assign pix_valid    = frame_active && (col >= front_porch) && ({1'b0, col} < line_stop);

   assign raster.row               = row;
   assign raster.col               = col;
   assign raster.frame_active      = frame_active;
   assign raster.pix_valid         = pix_valid;
   assign raster.line_end_of_frame = frame_last;
   assign raster.frame_count       = frame_count;
   assign raster.run               = enable && (state != st_idle);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state       <= st_idle;
         row         <= '0;
         col         <= '0;
         frame_count <= '0;
      end else if (!enable) begin
         state <= st_idle;
         row   <= '0;
         col   <= '0;
      end else if (state == st_idle) begin
         state <= st_run;
      end else begin
         state <= frame_last ? st_wrap : st_run;
         if (line_last) begin
            col <= '0;
            if (frame_last) begin
               row         <= '0;
               frame_count <= frame_count + 1'b1;
            end else begin
               row <= next_row[ROW_WIDTH-1:0];
            end
         end else begin
            col <= next_col[COL_WIDTH-1:0];
         end
      end
   end

   // sample geometry while disabled, when leaving idle and at row 0 column 0
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         active_rows_q  <= '0;
         virtual_rows_q <= '0;
         active_cols_q  <= '0;
         virtual_cols_q <= '0;
      end else if (!enable || state != st_run) begin
         active_rows_q  <= num_active_rows;
         virtual_rows_q <= num_virtual_rows;
         active_cols_q  <= num_active_cols;
         virtual_cols_q <= num_virtual_cols;
      end
   end

   // sync is active low, the window is checked only when the row changes
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         sync <= 1'b1;
      end else if (!enable) begin
         sync <= 1'b1;
      end else if (row_step) begin
         if (row_taken == sync_row_end) sync <= 1'b1;
         else if (row_taken == sync_row_start) sync <= 1'b0;
         else if (row_taken == '0) sync <= 1'b1;
      end
   end

   a_col_in_line: assert property (@(posedge clk) disable iff (!reset_n)
      (state != st_idle && total_cols != '0) |-> ({1'b0, col} < total_cols));

endmodule

/* src/imager_regs.sv */
`timescale 1ns/1ps

module imager_regs import imager_pkg::*; (
   input  logic                  clk,
   input  logic                  reset_n,
   // write address and data
   input  reg_addr_t             awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  reg_data_t             wdata,
   input  logic [3:0]            wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   // write response
   output logic [1:0]            bresp,
   output logic                  bvalid,
   input  logic                  bready,
   // read address and data
   input  reg_addr_t             araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output reg_data_t             rdata,
   output logic [1:0]            rresp,
   output logic                  rvalid,
   input  logic                  rready,
   input  frame_cnt_t            frame_count,
   // configuration
   output logic                  enable,
   output pattern_mode_t         mode,
   output row_t                  num_active_rows,
   output row_t                  num_virtual_rows,
   output col_t                  num_active_cols,
   output col_t                  num_virtual_cols,
   output logic [$bits(row_t):0] sync_row_start,
   output row_t                  sync_rows,
   output seed_t                 noise_seed
);

   // implemented bits per register
   localparam reg_data_t ctrl_mask  = 32'h0000_00F1;
   localparam reg_data_t geom_mask  = 32'h0FFF_0FFF;
   localparam reg_data_t sync_mask  = 32'h1FFF_0FFF;
   localparam reg_data_t seed_mask  = 32'hFFFF_FFFF;

   reg_data_t  ctrl_q;
   reg_data_t  active_q;
   reg_data_t  virtual_q;
   reg_data_t  sync_q;
   reg_data_t  seed_q;

   logic       aw_held;
   logic       w_held;
   reg_addr_t  aw_addr_q;
   reg_data_t  w_data_q;
   logic [3:0] w_strb_q;
   logic       aw_seen;
   logic       w_seen;
   logic       wr_fire;
   reg_addr_t  wr_addr;
   reg_data_t  wr_data;
   logic [3:0] wr_strb;
   reg_data_t  rd_mux;

   function automatic reg_data_t merge_bytes(input reg_data_t old_val,
                                             input reg_data_t new_val,
                                             input logic [3:0] strb,
                                             input reg_data_t field_mask);
      reg_data_t result;
      result = old_val;
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) result[8*i +: 8] = new_val[8*i +: 8];
      end
      return result & field_mask;
   endfunction

   // address and data may arrive in either order, one access at a time
   assign awready = !aw_held && !bvalid;
   assign wready  = !w_held && !bvalid;
   assign aw_seen = aw_held || (awvalid && awready);
   assign w_seen  = w_held || (wvalid && wready);
   assign wr_fire = aw_seen && w_seen;
   assign wr_addr = aw_held ? aw_addr_q : awaddr;
   assign wr_data = w_held ? w_data_q : wdata;
   assign wr_strb = w_held ? w_strb_q : wstrb;
   assign bresp   = 2'b00;

   always_ff @(posedge clk) begin
      if (awvalid && awready) aw_addr_q <= awaddr;
      if (wvalid && wready) begin
         w_data_q <= wdata;
         w_strb_q <= wstrb;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         if (bvalid && bready) bvalid <= 1'b0;
         if (wr_fire) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b1;
         end else begin
            if (awvalid && awready) aw_held <= 1'b1;
            if (wvalid && wready) w_held <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         ctrl_q    <= '0;
         active_q  <= '0;
         virtual_q <= '0;
         sync_q    <= '0;
         seed_q    <= '0;
      end else if (wr_fire) begin
         case ({wr_addr[5:2], 2'b00})
            reg_ctrl:    ctrl_q    <= merge_bytes(ctrl_q, wr_data, wr_strb, ctrl_mask);
            reg_active:  active_q  <= merge_bytes(active_q, wr_data, wr_strb, geom_mask);
            reg_virtual: virtual_q <= merge_bytes(virtual_q, wr_data, wr_strb, geom_mask);
            reg_sync:    sync_q    <= merge_bytes(sync_q, wr_data, wr_strb, sync_mask);
            reg_seed:    seed_q    <= merge_bytes(seed_q, wr_data, wr_strb, seed_mask);
            default: ;
         endcase
      end
   end

   // read side, data registered on the address handshake
   always_comb begin
      case ({araddr[5:2], 2'b00})
         reg_ctrl:    rd_mux = ctrl_q;
         reg_active:  rd_mux = active_q;
         reg_virtual: rd_mux = virtual_q;
         reg_sync:    rd_mux = sync_q;
         reg_seed:    rd_mux = seed_q;
         reg_status:  rd_mux = {16'h0000, frame_count};
         default:     rd_mux = '0;
      endcase
   end

   assign arready = !rvalid;
   assign rresp   = 2'b00;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) rvalid <= 1'b0;
      else if (arvalid && arready) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (arvalid && arready) rdata <= rd_mux;
   end

   assign enable           = ctrl_q[0];
   assign mode             = pattern_mode_t'(ctrl_q[7:4]);
   assign num_active_rows  = active_q[27:16];
   assign num_active_cols  = active_q[11:0];
   assign num_virtual_rows = virtual_q[27:16];
   assign num_virtual_cols = virtual_q[11:0];
   assign sync_row_start   = sync_q[28:16];
   assign sync_rows        = sync_q[11:0];
   assign noise_seed       = seed_q;

   // a response once offered is not withdrawn before the master takes it
   a_bvalid_held: assert property (@(posedge clk) disable iff (!reset_n)
      bvalid && !bready |=> bvalid);

endmodule

/* src/raster_if.sv */
`timescale 1ns/1ps

interface raster_if import imager_pkg::*; #(
   parameter int ROW_WIDTH = 12,
   parameter int COL_WIDTH = 12
);

   // current raster position
   logic [ROW_WIDTH-1:0] row;
   logic [COL_WIDTH-1:0] col;

   // line valid and frame valid before the output register
   logic                 pix_valid;
   logic                 frame_active;

   // last clock of the frame
   logic                 line_end_of_frame;

   frame_cnt_t           frame_count;

   // counters are running, low while disabled
   logic                 run;

   modport timing (
      output row, col, pix_valid, frame_active, line_end_of_frame, frame_count, run
   );

   modport pattern (
      input  row, col, pix_valid, frame_active, line_end_of_frame, frame_count, run
   );

endinterface

/* src/imager_pkg.sv */
package imager_pkg;

   // widths that carry a meaning across the design
   typedef logic [9:0]  pixel_t;
   typedef logic [11:0] row_t;
   typedef logic [11:0] col_t;
   typedef logic [15:0] frame_cnt_t;
   typedef logic [31:0] seed_t;

   // AXI4-Lite address and data
   typedef logic [5:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   // register map, byte offsets
   localparam reg_addr_t reg_ctrl    = 6'h00;
   localparam reg_addr_t reg_active  = 6'h04;
   localparam reg_addr_t reg_virtual = 6'h08;
   localparam reg_addr_t reg_sync    = 6'h0C;
   localparam reg_addr_t reg_seed    = 6'h10;
   localparam reg_addr_t reg_status  = 6'h14;

   // test patterns; 6 and anything above 8 fall back to bayer red
   typedef enum logic [3:0] {
      mode_noise      = 4'd0,
      mode_hgrad      = 4'd1,
      mode_vgrad      = 4'd2,
      mode_diag       = 4'd3,
      mode_frame      = 4'd4,
      mode_frame_diag = 4'd5,
      mode_counter    = 4'd7,
      mode_bayer      = 4'd8
   } pattern_mode_t;

   // frame timing FSM
   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_wrap
   } timing_state_t;

endpackage
